// ==== list.f ====
+incdir+verilog
verilog/axi_pkg.sv
verilog/stream_register.sv
verilog/axi_atop_filter.sv
verilog/axi_sram_slave.sv
verilog/axi_atop_mem_top.sv
tb/tb_axi_atop_mem.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it.
# The exit status is nonzero when the simulation ends in $fatal.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f \
  --top-module tb_axi_atop_mem -o sim_tb_axi_atop_mem &&
./obj_dir/sim_tb_axi_atop_mem || exit 1

// ==== tb/tb_axi_atop_mem.sv ====
// ========================================
// Directed testbench for the atop filter
// and SRAM slave, with memory scoreboard.
// ========================================

`timescale 1ns/1ps
`default_nettype none
`include "axi_defs.svh"

module tb_axi_atop_mem;

  // Worst case for all tests is about 625 cycles; the watchdog allows four times that.
  localparam int unsigned ClkPeriodNs = 8;
  localparam int unsigned TestCycles  = 625;
  localparam int unsigned TimeoutNs   = 4 * TestCycles * ClkPeriodNs;

  logic clk;
  logic rst_n;

  // Master-side channel drivers.
  axi_pkg::aw_chan_t aw;
  logic              aw_valid;
  axi_pkg::w_chan_t  w;
  logic              w_valid;
  logic              b_ready;
  axi_pkg::ar_chan_t ar;
  logic              ar_valid;
  logic              r_ready;

  axi_pkg::axi_req_t  req;
  axi_pkg::axi_resp_t resp;

  // Mirror of the SRAM contents.
  logic [`AXI_DATA_W-1:0] mem_model [`MEM_WORDS];
  logic [31:0]            lfsr_q;
  int unsigned            stall_bits;

  assign req = '{aw: aw, aw_valid: aw_valid, w: w, w_valid: w_valid, b_ready: b_ready,
                 ar: ar, ar_valid: ar_valid, r_ready: r_ready};

  axi_atop_mem_top axi_atop_mem_top_inst (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .slv_req_i  (req),
    .slv_resp_o (resp)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriodNs / 2) clk = ~clk;
  end

  // Galois LFSR, one step per returned bit.
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] bits;
    bits = '0;
    for (int unsigned k = 0; k < n; k++) begin
      bits   = {bits[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return bits;
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "value check %s failed", name);
    end
  endtask

  // AW then all W beats; the scoreboard takes only non-atomic data.
  task automatic send_write(input logic [3:0] id, input logic [15:0] addr,
                            input logic [7:0] len, input logic [5:0] atop,
                            input logic partial);
    logic [7:0]  idx;
    logic [31:0] data;
    logic [3:0]  strb;
    @(negedge clk);
    aw       = '{id: id, addr: addr, len: len, size: 3'd2, burst: `AXI_BURST_INCR,
                 atop: atop};
    aw_valid = 1'b1;
    #1;
    while (!resp.aw_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    aw_valid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      data    = take_bits(32);
      strb    = partial ? 4'(take_bits(4)) : 4'hf;
      w       = '{data: data, strb: strb, last: (i == int'(len))};
      w_valid = 1'b1;
      #1;
      while (!resp.w_ready) begin
        @(negedge clk);
        #1;
      end
      if (atop[5:4] == `AXI_ATOP_NONE) begin
        idx = addr[9:2] + 8'(i);
        for (int b = 0; b < `AXI_STRB_W; b++) begin
          if (strb[b]) mem_model[idx][b*8 +: 8] = data[b*8 +: 8];
        end
      end
      @(negedge clk);
    end
    w_valid = 1'b0;
  endtask

  task automatic send_ar(input logic [3:0] id, input logic [15:0] addr, input logic [7:0] len);
    @(negedge clk);
    ar       = '{id: id, addr: addr, len: len, size: 3'd2, burst: `AXI_BURST_INCR};
    ar_valid = 1'b1;
    #1;
    while (!resp.ar_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  // Takes one B after a random stall; the payload must hold while it waits.
  task automatic collect_b(input string name, input logic [3:0] exp_id,
                           input logic [1:0] exp_resp);
    axi_pkg::b_chan_t held;
    int unsigned      stall;
    int unsigned      waited;
    logic             seen;
    logic             done;
    stall  = take_bits(stall_bits);
    waited = 0;
    seen   = 1'b0;
    done   = 1'b0;
    held   = '0;
    while (!done) begin
      @(negedge clk);
      b_ready = (waited >= stall);
      #1;
      if (seen) begin
        compare({name, " b_valid held"}, 64'(1), 64'(resp.b_valid));
        compare({name, " b stable"}, 64'(held), 64'(resp.b));
      end
      if (resp.b_valid) begin
        if (b_ready) begin
          done = 1'b1;
        end else begin
          seen   = 1'b1;
          held   = resp.b;
          waited = waited + 1;
        end
      end
    end
    compare({name, " b"}, 64'({exp_id, exp_resp}), 64'(resp.b));
    @(negedge clk);
    b_ready = 1'b0;
  endtask

  // Takes len+1 R beats, each after its own stall, then expects R idle.
  task automatic collect_r(input string name, input logic [3:0] exp_id,
                           input logic [1:0] exp_resp, input logic [15:0] addr,
                           input logic [7:0] len, input logic from_mem);
    axi_pkg::r_chan_t held;
    axi_pkg::r_chan_t exp;
    int unsigned      stall;
    int unsigned      waited;
    int unsigned      beat;
    logic             seen;
    logic             done;
    held = '0;
    beat = 0;
    while (beat <= len) begin
      stall  = take_bits(stall_bits);
      waited = 0;
      seen   = 1'b0;
      done   = 1'b0;
      while (!done) begin
        @(negedge clk);
        r_ready = (waited >= stall);
        #1;
        if (seen) begin
          compare({name, " r_valid held"}, 64'(1), 64'(resp.r_valid));
          compare({name, " r stable"}, 64'(held), 64'(resp.r));
        end
        if (resp.r_valid) begin
          if (r_ready) begin
            done = 1'b1;
          end else begin
            seen   = 1'b1;
            held   = resp.r;
            waited = waited + 1;
          end
        end
      end
      exp.id   = exp_id;
      exp.data = from_mem ? mem_model[addr[9:2] + 8'(beat)] : '0;
      exp.resp = exp_resp;
      exp.last = (beat == len);
      compare({name, " r beat"}, 64'(exp), 64'(resp.r));
      beat = beat + 1;
    end
    @(negedge clk);
    r_ready = 1'b0;
    #1;
    compare({name, " r after last"}, 64'(0), 64'(resp.r_valid));
  endtask

  task automatic reset_and_write();
    compare("reset b_valid", 64'(0), 64'(resp.b_valid));
    compare("reset r_valid", 64'(0), 64'(resp.r_valid));
    send_write(4'h3, 16'h0040, 8'd3, 6'h00, 1'b0);
    collect_b("incr write", 4'h3, `AXI_RESP_OKAY);
  endtask

  task automatic partial_strobe_read();
    send_write(4'h5, 16'h0040, 8'd3, 6'h00, 1'b1);
    collect_b("partial write", 4'h5, `AXI_RESP_OKAY);
    send_ar(4'h9, 16'h0040, 8'd3);
    collect_r("partial read", 4'h9, `AXI_RESP_OKAY, 16'h0040, 8'd3, 1'b1);
  endtask

  // Store kind: bits 5:4 are 01, so no read data comes back.
  task automatic atomic_store();
    send_write(4'h7, 16'h0040, 8'd1, 6'h12, 1'b0);
    collect_b("atomic store", 4'h7, `AXI_RESP_SLVERR);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      #1;
      compare("atomic store no r", 64'(0), 64'(resp.r_valid));
    end
    send_ar(4'h2, 16'h0040, 8'd3);
    collect_r("after store read", 4'h2, `AXI_RESP_OKAY, 16'h0040, 8'd3, 1'b1);
  endtask

  // Load kind sets bit 5; B and R may come in either order.
  task automatic atomic_load(input string name, input logic [3:0] id, input logic [7:0] len);
    send_write(id, 16'h0080, len, 6'h20, 1'b0);
    fork
      collect_b(name, id, `AXI_RESP_SLVERR);
      collect_r(name, id, `AXI_RESP_SLVERR, 16'h0000, len, 1'b0);
    join
  endtask

  // Longer stalls on both response channels.
  task automatic backpressure();
    stall_bits = 4;
    atomic_load("stalled load", 4'he, 8'd1);
    send_write(4'h8, 16'h0100, 8'd7, 6'h00, 1'b0);
    collect_b("stalled write", 4'h8, `AXI_RESP_OKAY);
    send_ar(4'ha, 16'h0100, 8'd7);
    collect_r("stalled read", 4'ha, `AXI_RESP_OKAY, 16'h0100, 8'd7, 1'b1);
    stall_bits = 2;
  endtask

  // The plain AW waits behind the injected B, then passes.
  task automatic write_after_atomic();
    send_write(4'h1, 16'h00c0, 8'd0, 6'h15, 1'b0);
    fork
      collect_b("store before write", 4'h1, `AXI_RESP_SLVERR);
      send_write(4'h6, 16'h00c0, 8'd2, 6'h00, 1'b0);
    join
    collect_b("write after atomic", 4'h6, `AXI_RESP_OKAY);
    send_ar(4'h4, 16'h00c0, 8'd2);
    collect_r("read after atomic", 4'h4, `AXI_RESP_OKAY, 16'h00c0, 8'd2, 1'b1);
  endtask

  initial begin
    lfsr_q     = 32'he316;
    stall_bits = 2;
    rst_n      = 1'b0;
    aw         = '0;
    aw_valid   = 1'b0;
    w          = '0;
    w_valid    = 1'b0;
    b_ready    = 1'b0;
    ar         = '0;
    ar_valid   = 1'b0;
    r_ready    = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    reset_and_write();
    partial_strobe_read();
    atomic_store();
    atomic_load("atomic load", 4'hc, 8'd3);
    backpressure();
    write_after_atomic();
    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: the tests did not finish within %0d ns", TimeoutNs);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== verilog/axi_atop_filter.sv ====
// ========================================
// AXI atop filter: W/R FSMs, burst count,
// SLVERR B and R injection.
// ========================================

`timescale 1ns/1ps
`default_nettype none
`include "axi_defs.svh"

module axi_atop_filter #(
  parameter int unsigned MaxWriteTxns = `MAX_WRITE_TXNS
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire axi_pkg::axi_req_t  slv_req_i,
  output axi_pkg::axi_resp_t      slv_resp_o,
  output axi_pkg::axi_req_t       mst_req_o,
  input  wire axi_pkg::axi_resp_t mst_resp_i
);

  // Two bits minimum so that minus one is distinguishable.
  localparam int unsigned CntW = (MaxWriteTxns == 1) ? 2 : $clog2(MaxWriteTxns + 1);

  typedef struct packed {
    logic            underflow;
    logic [CntW-1:0] cnt;
  } w_cnt_t;

  w_cnt_t               w_cnt_d, w_cnt_q;
  axi_pkg::w_state_e    w_state_d, w_state_q;
  axi_pkg::r_state_e    r_state_d, r_state_q;
  logic [`AXI_ID_W-1:0] id_d, id_q;
  logic [7:0]           r_beats_d, r_beats_q;
  logic [7:0]           r_cmd_len;

  logic aw_wo_w, w_wo_aw;
  logic aw_atomic, w_last_beat, b_busy;
  logic aw_pass, aw_absorb, w_pass, w_absorb, b_inject;
  logic r_inject, r_last;
  logic r_cmd_push_valid, r_cmd_push_ready, r_cmd_pop_valid, r_cmd_pop_ready;

  // AW downstream still waiting for its W burst.
  assign aw_wo_w = !w_cnt_q.underflow && (w_cnt_q.cnt != '0);
  // Complete W burst downstream ahead of its AW (count of minus one).
  assign w_wo_aw = w_cnt_q.underflow && (&w_cnt_q.cnt);

  assign aw_atomic   = slv_req_i.aw_valid && (slv_req_i.aw.atop[5:4] != `AXI_ATOP_NONE);
  assign w_last_beat = slv_req_i.w_valid && slv_req_i.w.last;
  // Pass-through B that has not yet been taken.
  assign b_busy      = mst_resp_i.b_valid && !slv_req_i.b_ready;

  // W-side FSM.
  always_comb begin
    aw_pass          = 1'b0;
    aw_absorb        = 1'b0;
    w_pass           = 1'b0;
    w_absorb         = 1'b0;
    b_inject         = 1'b0;
    id_d             = id_q;
    r_cmd_push_valid = 1'b0;
    w_state_d        = w_state_q;
    unique case (w_state_q)
      axi_pkg::W_RESET: w_state_d = axi_pkg::W_FEEDTHROUGH;
      axi_pkg::W_FEEDTHROUGH: begin
        // AW passes below the outstanding limit.
        aw_pass = w_wo_aw || (w_cnt_q.cnt < MaxWriteTxns);
        // W passes for a missing burst, or with a plain AW on the bus.
        w_pass  = aw_wo_w || (slv_req_i.aw_valid && !aw_atomic && !w_wo_aw);
        if (aw_atomic) begin
          aw_pass = 1'b0;
          if (aw_wo_w) begin
            // Hold the atomic AW until earlier W bursts are complete.
            w_state_d = axi_pkg::BLOCK_AW;
          end else begin
            // Swallow the atomic AW and keep its ID.
            aw_absorb        = 1'b1;
            id_d             = slv_req_i.aw.id;
            r_cmd_push_valid = slv_req_i.aw.atop[`AXI_ATOP_RRESP];
            w_pass           = 1'b0;
            w_absorb         = 1'b1;
            if (w_last_beat) begin
              w_state_d = b_busy ? axi_pkg::HOLD_B : axi_pkg::INJECT_B;
            end else begin
              w_state_d = axi_pkg::ABSORB_W;
            end
          end
        end
      end
      axi_pkg::BLOCK_AW: begin
        // Let earlier W bursts finish first.
        if (aw_wo_w) begin
          w_pass = 1'b1;
        end else begin
          // Now take the waiting atomic AW.
          aw_absorb        = 1'b1;
          id_d             = slv_req_i.aw.id;
          r_cmd_push_valid = slv_req_i.aw.atop[`AXI_ATOP_RRESP];
          w_absorb         = 1'b1;
          if (w_last_beat) begin
            w_state_d = b_busy ? axi_pkg::HOLD_B : axi_pkg::INJECT_B;
          end else begin
            w_state_d = axi_pkg::ABSORB_W;
          end
        end
      end
      axi_pkg::ABSORB_W: begin
        w_absorb = 1'b1;
        if (w_last_beat) begin
          w_state_d = b_busy ? axi_pkg::HOLD_B : axi_pkg::INJECT_B;
        end
      end
      axi_pkg::HOLD_B: begin
        // Wait for the stalled pass-through B.
        if (mst_resp_i.b_valid && slv_req_i.b_ready) begin
          w_state_d = axi_pkg::INJECT_B;
        end
      end
      axi_pkg::INJECT_B: begin
        b_inject = 1'b1;
        if (slv_req_i.b_ready) begin
          if (r_cmd_pop_valid && !r_cmd_pop_ready) begin
            w_state_d = axi_pkg::WAIT_R;
          end else begin
            w_state_d = axi_pkg::W_FEEDTHROUGH;
          end
        end
      end
      axi_pkg::WAIT_R: begin
        // Stored ID is needed until the R burst is out.
        if (!r_cmd_pop_valid) begin
          w_state_d = axi_pkg::W_FEEDTHROUGH;
        end
      end
      default: w_state_d = axi_pkg::W_RESET;
    endcase
  end

  assign r_last = (r_beats_q == '0);

  // R-side FSM.
  always_comb begin
    r_inject        = 1'b0;
    r_cmd_pop_ready = 1'b0;
    r_beats_d       = r_beats_q;
    r_state_d       = r_state_q;
    unique case (r_state_q)
      axi_pkg::R_RESET: r_state_d = axi_pkg::R_FEEDTHROUGH;
      axi_pkg::R_FEEDTHROUGH: begin
        if (mst_resp_i.r_valid && !slv_req_i.r_ready) begin
          r_state_d = axi_pkg::R_HOLD;
        end else if (r_cmd_pop_valid && !mst_resp_i.r_valid) begin
          // Start injection only while the pass-through R is idle.
          r_beats_d = r_cmd_len;
          r_state_d = axi_pkg::INJECT_R;
        end
      end
      axi_pkg::INJECT_R: begin
        r_inject = 1'b1;
        if (slv_req_i.r_ready) begin
          if (r_last) begin
            r_cmd_pop_ready = 1'b1;
            r_state_d       = axi_pkg::R_FEEDTHROUGH;
          end else begin
            r_beats_d = r_beats_q - 8'd1;
          end
        end
      end
      axi_pkg::R_HOLD: begin
        if (mst_resp_i.r_valid && slv_req_i.r_ready) begin
          r_state_d = axi_pkg::R_FEEDTHROUGH;
        end
      end
      default: r_state_d = axi_pkg::R_RESET;
    endcase
  end

  // Port muxing.
  always_comb begin
    mst_req_o          = slv_req_i;
    mst_req_o.aw.atop  = '0;
    mst_req_o.aw_valid = slv_req_i.aw_valid && aw_pass;
    mst_req_o.w_valid  = slv_req_i.w_valid && w_pass;
    mst_req_o.b_ready  = slv_req_i.b_ready && !b_inject;
    mst_req_o.r_ready  = slv_req_i.r_ready && !r_inject;

    slv_resp_o          = mst_resp_i;
    slv_resp_o.aw_ready = aw_absorb || (aw_pass && mst_resp_i.aw_ready);
    slv_resp_o.w_ready  = w_absorb || (w_pass && mst_resp_i.w_ready);
    if (b_inject) begin
      slv_resp_o.b_valid = 1'b1;
      slv_resp_o.b.id    = id_q;
      slv_resp_o.b.resp  = `AXI_RESP_SLVERR;
    end
    if (r_inject) begin
      slv_resp_o.r_valid = 1'b1;
      slv_resp_o.r       = '0;
      slv_resp_o.r.id    = id_q;
      slv_resp_o.r.resp  = `AXI_RESP_SLVERR;
      slv_resp_o.r.last  = r_last;
    end
  end

  // Downstream AW minus complete W bursts.
  always_comb begin
    w_cnt_d = w_cnt_q;
    if (mst_req_o.aw_valid && mst_resp_i.aw_ready) begin
      w_cnt_d.cnt = w_cnt_d.cnt + 1'b1;
    end
    if (mst_req_o.w_valid && mst_resp_i.w_ready && mst_req_o.w.last) begin
      w_cnt_d.cnt = w_cnt_d.cnt - 1'b1;
    end
    if (w_cnt_q.underflow && (w_cnt_d.cnt == '0)) begin
      w_cnt_d.underflow = 1'b0;
    end else if ((w_cnt_q.cnt == '0) && (&w_cnt_d.cnt)) begin
      w_cnt_d.underflow = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q <= axi_pkg::W_RESET;
      r_state_q <= axi_pkg::R_RESET;
      w_cnt_q   <= '0;
      id_q      <= '0;
      r_beats_q <= '0;
    end else begin
      w_state_q <= w_state_d;
      r_state_q <= r_state_d;
      w_cnt_q   <= w_cnt_d;
      id_q      <= id_d;
      r_beats_q <= r_beats_d;
    end
  end

  // Length of the R burst still owed.
  stream_register #(
    .T (logic [7:0])
  ) r_cmd_reg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (r_cmd_push_valid),
    .ready_o (r_cmd_push_ready),
    .data_i  (slv_req_i.aw.len),
    .valid_o (r_cmd_pop_valid),
    .ready_i (r_cmd_pop_ready),
    .data_o  (r_cmd_len)
  );

  // Downstream never sees an atomic write.
  a_no_atop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_atomic |-> !mst_req_o.aw_valid);

  // Injected B holds its payload until taken.
  a_inject_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (b_inject && !slv_req_i.b_ready) |=> (slv_resp_o.b_valid && $stable(slv_resp_o.b)));

  // Command buffer has drained before the next atomic AW.
  a_cmd_push: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_cmd_push_valid |-> r_cmd_push_ready);

endmodule

`default_nettype wire

// ==== verilog/axi_atop_mem_top.sv ====
// ========================================
// Atop filter in front of the SRAM slave.
// ========================================

`timescale 1ns/1ps
`default_nettype none
`include "axi_defs.svh"

module axi_atop_mem_top (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire axi_pkg::axi_req_t  slv_req_i,
  output axi_pkg::axi_resp_t      slv_resp_o
);

  // Filtered bus between the two blocks.
  axi_pkg::axi_req_t  mem_req;
  axi_pkg::axi_resp_t mem_resp;

  axi_atop_filter #(
    .MaxWriteTxns (`MAX_WRITE_TXNS)
  ) axi_atop_filter_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req_i),
    .slv_resp_o (slv_resp_o),
    .mst_req_o  (mem_req),
    .mst_resp_i (mem_resp)
  );

  axi_sram_slave axi_sram_slave_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (mem_req),
    .resp_o (mem_resp)
  );

endmodule

`default_nettype wire

// ==== verilog/axi_defs.svh ====
// ========================================
// AXI widths, response and burst codes,
// atop fields and memory limits.
// ========================================

`ifndef AXI_DEFS_SVH
`define AXI_DEFS_SVH

// Channel widths.
`define AXI_ID_W        4
`define AXI_ADDR_W      16
`define AXI_DATA_W      32
`define AXI_STRB_W      4

// Atop bits 5:4 equal to this value mean an ordinary write.
`define AXI_ATOP_NONE   2'b00
// Atop bit that asks for read data on top of the B response.
`define AXI_ATOP_RRESP  5

// Response and burst codes.
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10
`define AXI_BURST_INCR  2'b01

// Memory depth in 32-bit words.
`define MEM_WORDS       256
// Default limit on outstanding downstream writes.
`define MAX_WRITE_TXNS  4

`endif

// ==== verilog/axi_pkg.sv ====
// ========================================
// AXI channel structs, request/response
// bundles and FSM state enums.
// ========================================

`default_nettype none

package axi_pkg;

  `include "axi_defs.svh"

  // Write address channel.
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
    logic [5:0]             atop;
  } aw_chan_t;

  // Write data channel.
  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } w_chan_t;

  // Write response channel.
  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    logic [1:0]           resp;
  } b_chan_t;

  // Read address channel.
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
  } ar_chan_t;

  // Read data channel.
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    logic [1:0]             resp;
    logic                   last;
  } r_chan_t;

  // Everything driven by the master.
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything driven by the slave.
  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    logic    w_ready;
    logic    b_valid;
    b_chan_t b;
    logic    r_valid;
    r_chan_t r;
  } axi_resp_t;

  // Filter W-side states.
  typedef enum logic [2:0] {
    W_RESET, W_FEEDTHROUGH, BLOCK_AW, ABSORB_W, HOLD_B, INJECT_B, WAIT_R
  } w_state_e;

  // Filter R-side states.
  typedef enum logic [1:0] {
    R_RESET, R_FEEDTHROUGH, INJECT_R, R_HOLD
  } r_state_e;

  // SRAM slave write and read phases.
  typedef enum logic [1:0] {
    MEM_WR_IDLE, MEM_WR_DATA, MEM_WR_RESP
  } mem_wr_state_e;

  typedef enum logic {
    MEM_RD_IDLE, MEM_RD_DATA
  } mem_rd_state_e;

endpackage

`default_nettype wire

// ==== verilog/axi_sram_slave.sv ====
// ========================================
// AXI slave over a word-addressed SRAM.
// ========================================

`timescale 1ns/1ps
`default_nettype none
`include "axi_defs.svh"

module axi_sram_slave (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire axi_pkg::axi_req_t req_i,
  output axi_pkg::axi_resp_t     resp_o
);

  localparam int unsigned IdxW = $clog2(`MEM_WORDS);

  // Captured burst attributes.
  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    logic [IdxW-1:0]      idx;
    logic [7:0]           len;
  } burst_t;

  logic [`AXI_DATA_W-1:0] mem_q [`MEM_WORDS];

  axi_pkg::mem_wr_state_e wr_state_q;
  axi_pkg::mem_rd_state_e rd_state_q;
  burst_t                 wr_burst_q, rd_burst_q;
  logic [7:0]             wr_beat_q, rd_beat_q;
  logic [IdxW-1:0]        wr_idx, rd_idx;
  logic                   aw_hs, ar_hs, mem_we;

  assign aw_hs  = req_i.aw_valid && (wr_state_q == axi_pkg::MEM_WR_IDLE);
  assign ar_hs  = req_i.ar_valid && (rd_state_q == axi_pkg::MEM_RD_IDLE);
  assign mem_we = req_i.w_valid && (wr_state_q == axi_pkg::MEM_WR_DATA);

  // Every burst is INCR over whole words.
  assign wr_idx = IdxW'(wr_burst_q.idx + wr_beat_q);
  assign rd_idx = IdxW'(rd_burst_q.idx + rd_beat_q);

  // Write side.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_state_q <= axi_pkg::MEM_WR_IDLE;
      wr_beat_q  <= '0;
    end else begin
      unique case (wr_state_q)
        axi_pkg::MEM_WR_IDLE: begin
          if (aw_hs) begin
            wr_state_q <= axi_pkg::MEM_WR_DATA;
            wr_beat_q  <= '0;
          end
        end
        axi_pkg::MEM_WR_DATA: begin
          if (req_i.w_valid) begin
            if (wr_beat_q == wr_burst_q.len) begin
              wr_state_q <= axi_pkg::MEM_WR_RESP;
            end else begin
              wr_beat_q <= wr_beat_q + 8'd1;
            end
          end
        end
        axi_pkg::MEM_WR_RESP: begin
          if (req_i.b_ready) begin
            wr_state_q <= axi_pkg::MEM_WR_IDLE;
          end
        end
        default: wr_state_q <= axi_pkg::MEM_WR_IDLE;
      endcase
    end
  end

  // Read side.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_state_q <= axi_pkg::MEM_RD_IDLE;
      rd_beat_q  <= '0;
    end else if (ar_hs) begin
      rd_state_q <= axi_pkg::MEM_RD_DATA;
      rd_beat_q  <= '0;
    end else if ((rd_state_q == axi_pkg::MEM_RD_DATA) && req_i.r_ready) begin
      if (rd_beat_q == rd_burst_q.len) begin
        rd_state_q <= axi_pkg::MEM_RD_IDLE;
      end else begin
        rd_beat_q <= rd_beat_q + 8'd1;
      end
    end
  end

  // Burst capture and byte-strobed memory writes.
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      wr_burst_q <= '{id: req_i.aw.id, idx: req_i.aw.addr[IdxW+1:2], len: req_i.aw.len};
    end
    if (ar_hs) begin
      rd_burst_q <= '{id: req_i.ar.id, idx: req_i.ar.addr[IdxW+1:2], len: req_i.ar.len};
    end
    if (mem_we) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (req_i.w.strb[b]) begin
          mem_q[wr_idx][b*8 +: 8] <= req_i.w.data[b*8 +: 8];
        end
      end
    end
  end

  // Response port.
  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = (wr_state_q == axi_pkg::MEM_WR_IDLE);
    resp_o.w_ready  = (wr_state_q == axi_pkg::MEM_WR_DATA);
    resp_o.b_valid  = (wr_state_q == axi_pkg::MEM_WR_RESP);
    resp_o.b.id     = wr_burst_q.id;
    resp_o.b.resp   = `AXI_RESP_OKAY;
    resp_o.ar_ready = (rd_state_q == axi_pkg::MEM_RD_IDLE);
    resp_o.r_valid  = (rd_state_q == axi_pkg::MEM_RD_DATA);
    resp_o.r.id     = rd_burst_q.id;
    resp_o.r.data   = mem_q[rd_idx];
    resp_o.r.resp   = `AXI_RESP_OKAY;
    resp_o.r.last   = (rd_beat_q == rd_burst_q.len);
  end

  // The upstream filter keeps atomics away from this memory.
  a_no_atop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_hs |-> (req_i.aw.atop == '0));

endmodule

`default_nettype wire

// ==== verilog/stream_register.sv ====
// ========================================
// One-entry valid/ready register.
// ========================================

`timescale 1ns/1ps
`default_nettype none

module stream_register #(
  parameter type T = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic valid_i,
  output logic      ready_o,
  input  wire T     data_i,
  output logic      valid_o,
  input  wire logic ready_i,
  output T          data_o
);

  logic valid_q;
  T     data_q;

  // Room for a new item when empty or drained this cycle.
  assign ready_o = !valid_q || ready_i;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  // Occupancy flag.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Stored item.
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire
